// ==== src/dla_defs.svh ====
`ifndef DLA_DEFS_SVH
`define DLA_DEFS_SVH

// array shape
`define DLA_TN              4   // lanes, one per input channel
`define DLA_KERNEL_SIZE     3   // kernel side
`define DLA_TAPS            9   // KERNEL_SIZE squared

// datapath widths
`define DLA_FEATURE_WIDTH   8
`define DLA_SCALE_WIDTH     16
`define DLA_RESULT_WIDTH    32

// command opcodes on i_cmd_op
`define DLA_OP_LOAD_WEIGHT  0
`define DLA_OP_LOAD_FEATURE 1
`define DLA_OP_LOAD_SCALE   2
`define DLA_OP_RUN          3

`endif

// ==== src/dla_pkg.sv ====
`include "dla_defs.svh"

package dla_pkg;

    ////////////////////////////////////////////////////////////
    // command channel
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OP_LOAD_WEIGHT  = `DLA_OP_LOAD_WEIGHT,
        OP_LOAD_FEATURE = `DLA_OP_LOAD_FEATURE,
        OP_LOAD_SCALE   = `DLA_OP_LOAD_SCALE,
        OP_RUN          = `DLA_OP_RUN
    } opcode_t;

    typedef logic [$clog2(`DLA_TN)-1:0] lane_idx_t;

    ////////////////////////////////////////////////////////////
    // ternary datapath
    ////////////////////////////////////////////////////////////

    // weight code, 00 and 10 both count as zero
    typedef logic [1:0] tern_t;
    localparam tern_t TERN_PLUS  = 2'b01;
    localparam tern_t TERN_MINUS = 2'b11;

    typedef logic signed [`DLA_FEATURE_WIDTH-1:0] feature_t;

    typedef tern_t    [`DLA_TAPS-1:0] kernel_t;  // tap 0 in low bits
    typedef feature_t [`DLA_TAPS-1:0] window_t;  // tap 0 in low bits

    // 9 taps of +-128 need 4 more bits
    typedef logic signed [`DLA_FEATURE_WIDTH+$clog2(`DLA_TAPS)-1:0] lane_sum_t;
    typedef logic signed [$bits(lane_sum_t)+$clog2(`DLA_TN)-1:0] chan_sum_t;

    typedef logic signed [`DLA_SCALE_WIDTH-1:0]  scale_t;
    typedef logic signed [`DLA_RESULT_WIDTH-1:0] result_t;

endpackage

// ==== src/lane_load_if.sv ====
`timescale 1ns/1ps

// decoder to lane broadcast bus
interface lane_load_if
    import dla_pkg::*;
();

    logic      wr_kernel;   // kernel write strobe
    logic      wr_window;   // window write strobe
    lane_idx_t sel_lane;    // target lane of a write
    kernel_t   kernel;
    window_t   window;
    logic      run;         // one-cycle run pulse, all lanes

    modport decoder (
        output wr_kernel,
        output wr_window,
        output sel_lane,
        output kernel,
        output window,
        output run
    );

    modport lane (
        input  wr_kernel,
        input  wr_window,
        input  sel_lane,
        input  kernel,
        input  window,
        input  run
    );

endinterface

// ==== src/cmd_decode.sv ====
`timescale 1ns/1ps
`include "dla_defs.svh"

module cmd_decode
    import dla_pkg::*;
(
    input  logic         clk,
    input  logic         i_rst_n,
    input  logic         i_cmd_req,
    input  opcode_t      i_cmd_op,
    input  lane_idx_t    i_cmd_lane,
    input  window_t      i_cmd_data,
    output logic         o_cmd_ack,
    lane_load_if.decoder load,
    output scale_t       o_scale,
    input  logic         i_busy
);

    typedef enum logic [1:0] {
        S_IDLE,     // waiting for req
        S_HOLD,     // RUN seen, accumulator still busy
        S_ACK       // ack high, waiting for req low
    } cmd_state_t;

    cmd_state_t state;
    logic [$bits(window_t)-1:0] cmd_bits;  // flat view for low-bit slices
    logic       take;                      // new command sampled this edge

    assign cmd_bits = i_cmd_data;
    assign take     = (state == S_IDLE) && i_cmd_req;

    ////////////////////////////////////////////////////////////
    // handshake fsm and strobes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state          <= S_IDLE;
            o_cmd_ack      <= 1'b0;
            load.wr_kernel <= 1'b0;
            load.wr_window <= 1'b0;
            load.run       <= 1'b0;
            o_scale        <= scale_t'(1);  // unity gain
        end else begin
            load.wr_kernel <= 1'b0;  // strobes last one cycle
            load.wr_window <= 1'b0;
            load.run       <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_cmd_req) begin
                        case (i_cmd_op)
                            OP_LOAD_WEIGHT: begin
                                load.wr_kernel <= 1'b1;
                                o_cmd_ack      <= 1'b1;
                                state          <= S_ACK;
                            end
                            OP_LOAD_FEATURE: begin
                                load.wr_window <= 1'b1;
                                o_cmd_ack      <= 1'b1;
                                state          <= S_ACK;
                            end
                            OP_LOAD_SCALE: begin
                                o_scale   <= cmd_bits[`DLA_SCALE_WIDTH-1:0];
                                o_cmd_ack <= 1'b1;
                                state     <= S_ACK;
                            end
                            OP_RUN: begin
                                if (!i_busy) begin
                                    load.run  <= 1'b1;
                                    o_cmd_ack <= 1'b1;
                                    state     <= S_ACK;
                                end else begin
                                    state <= S_HOLD;  // result slot taken
                                end
                            end
                        endcase
                    end
                end
                S_HOLD: begin
                    if (!i_busy) begin  // slot free, issue now
                        load.run  <= 1'b1;
                        o_cmd_ack <= 1'b1;
                        state     <= S_ACK;
                    end
                end
                S_ACK: begin
                    if (!i_cmd_req) begin
                        o_cmd_ack <= 1'b0;
                        state     <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // payload captured with the command, master may change it after ack
    always_ff @(posedge clk) begin
        if (take) begin
            load.sel_lane <= i_cmd_lane;
            load.kernel   <= cmd_bits[$bits(kernel_t)-1:0];  // low 18 bits
            load.window   <= i_cmd_data;
        end
    end

endmodule

// ==== src/tern_lane.sv ====
`timescale 1ns/1ps
`include "dla_defs.svh"

module tern_lane
    import dla_pkg::*;
#(
    parameter lane_idx_t LANE_ID = '0
)(
    input  logic          clk,
    input  logic          i_rst_n,
    lane_load_if.lane     load,
    output lane_sum_t     o_sum,
    output logic          o_sum_valid
);

    kernel_t   kernel_q;
    window_t   window_q;
    lane_sum_t sum_d;
    logic      hit;     // write addressed to this lane

    assign hit = (load.sel_lane == LANE_ID);

    // kernel and window storage
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            kernel_q <= '0;
            window_q <= '0;
        end else begin
            if (load.wr_kernel && hit)
                kernel_q <= load.kernel;
            if (load.wr_window && hit)
                window_q <= load.window;
        end
    end

    // select-and-sum over the taps
    always_comb begin
        feature_t f;
        sum_d = '0;
        for (int t = 0; t < `DLA_TAPS; t++) begin
            f = window_q[t];
            case (kernel_q[t])
                TERN_PLUS:  sum_d = sum_d + f;
                TERN_MINUS: sum_d = sum_d - f;
                default:    sum_d = sum_d;  // 00 and 10 skip the tap
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n)
            o_sum_valid <= 1'b0;
        else
            o_sum_valid <= load.run;  // one cycle after run
    end

    always_ff @(posedge clk) begin
        if (load.run)
            o_sum <= sum_d;  // held until next run
    end

endmodule

// ==== src/chan_accum.sv ====
`timescale 1ns/1ps
`include "dla_defs.svh"

module chan_accum
    import dla_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst_n,
    input  lane_sum_t i_lane_sum [`DLA_TN],
    input  logic      i_sum_valid,
    input  scale_t    i_scale,
    output logic      o_busy,
    output logic      o_res_req,
    input  logic      i_res_ack,
    output result_t   o_res_data
);

    localparam int PAIRS = `DLA_TN / 2;

    typedef enum logic [1:0] {
        R_IDLE,     // no result pending
        R_REQ,      // req high, waiting for ack
        R_DROP      // req low, waiting for ack low
    } res_state_t;

    logic signed [$bits(lane_sum_t):0] pair_sum [PAIRS];  // level one
    chan_sum_t  tree_sum;                                 // level two
    chan_sum_t  chan_sum_q;
    scale_t     scale_q;     // scale frozen with its run
    logic       stage1_vld;
    logic       busy_q;
    res_state_t res_state;

    ////////////////////////////////////////////////////////////
    // stage one, channel adder tree
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < PAIRS; i++)
            pair_sum[i] = i_lane_sum[2*i] + i_lane_sum[2*i+1];
    end

    always_comb begin
        tree_sum = '0;
        for (int i = 0; i < PAIRS; i++)
            tree_sum = tree_sum + pair_sum[i];
    end

    always_ff @(posedge clk) begin
        if (i_sum_valid) begin
            chan_sum_q <= tree_sum;
            scale_q    <= i_scale;  // later LOAD_SCALE can't touch this run
        end
    end

    ////////////////////////////////////////////////////////////
    // stage two, scaler multiply into result register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (stage1_vld)
            o_res_data <= result_t'(chan_sum_q) * result_t'(scale_q);
    end

    // result handshake and busy
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            stage1_vld <= 1'b0;
            busy_q     <= 1'b0;
            o_res_req  <= 1'b0;
            res_state  <= R_IDLE;
        end else begin
            stage1_vld <= i_sum_valid;
            if (i_sum_valid)
                busy_q <= 1'b1;
            case (res_state)
                R_IDLE: begin
                    if (stage1_vld) begin
                        o_res_req <= 1'b1;  // data lands same edge
                        res_state <= R_REQ;
                    end
                end
                R_REQ: begin
                    if (i_res_ack) begin
                        o_res_req <= 1'b0;
                        res_state <= R_DROP;
                    end
                end
                R_DROP: begin
                    if (!i_res_ack) begin  // four-phase closed
                        busy_q    <= 1'b0;
                        res_state <= R_IDLE;
                    end
                end
                default: res_state <= R_IDLE;
            endcase
        end
    end

    // cover the gap before busy_q sets
    assign o_busy = busy_q | i_sum_valid;

endmodule

// ==== src/dla_top.sv ====
`timescale 1ns/1ps
`include "dla_defs.svh"

module dla_top
    import dla_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst_n,

    // command channel, slave side
    input  logic      i_cmd_req,
    input  opcode_t   i_cmd_op,
    input  lane_idx_t i_cmd_lane,
    input  window_t   i_cmd_data,
    output logic      o_cmd_ack,

    // result channel, master side
    output logic      o_res_req,
    input  logic      i_res_ack,
    output result_t   o_res_data
);

    lane_load_if load_bus ();

    scale_t              scale;
    logic                busy;
    lane_sum_t           lane_sum [`DLA_TN];
    logic [`DLA_TN-1:0]  lane_valid;  // all lanes pulse together

    cmd_decode instruction_decoder (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_cmd_req  (i_cmd_req),
        .i_cmd_op   (i_cmd_op),
        .i_cmd_lane (i_cmd_lane),
        .i_cmd_data (i_cmd_data),
        .o_cmd_ack  (o_cmd_ack),
        .load       (load_bus),
        .o_scale    (scale),
        .i_busy     (busy)
    );

    ////////////////////////////////////////////////////////////
    // ternary lanes, one per input channel
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < `DLA_TN; g++) begin : g_lane
        tern_lane #(
            .LANE_ID (lane_idx_t'(g))
        ) ternary_lane (
            .clk         (clk),
            .i_rst_n     (i_rst_n),
            .load        (load_bus),
            .o_sum       (lane_sum[g]),
            .o_sum_valid (lane_valid[g])
        );
    end

    chan_accum channel_adder_tree (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_lane_sum  (lane_sum),
        .i_sum_valid (lane_valid[0]),  // lane 0 stands for all
        .i_scale     (scale),
        .o_busy      (busy),
        .o_res_req   (o_res_req),
        .i_res_ack   (i_res_ack),
        .o_res_data  (o_res_data)
    );

endmodule

// ==== verif/dla_tb.sv ====
`timescale 1ns/1ps
`include "dla_defs.svh"

module dla_tb
    import dla_pkg::*;
();

    localparam int WAIT_LIMIT = 100;  // cycles allowed per handshake wait

    logic      clk;
    logic      i_rst_n;
    logic      i_cmd_req;
    opcode_t   i_cmd_op;
    lane_idx_t i_cmd_lane;
    window_t   i_cmd_data;
    logic      o_cmd_ack;
    logic      o_res_req;
    logic      i_res_ack;
    result_t   o_res_data;

    // shadow state for the reference model
    kernel_t     kern_sh [`DLA_TN];
    window_t     win_sh  [`DLA_TN];
    scale_t      scale_sh;
    logic [31:0] lcg_state;
    int          errors;
    int          checks;

    dla_top i_dut (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_cmd_req  (i_cmd_req),
        .i_cmd_op   (i_cmd_op),
        .i_cmd_lane (i_cmd_lane),
        .i_cmd_data (i_cmd_data),
        .o_cmd_ack  (o_cmd_ack),
        .o_res_req  (o_res_req),
        .i_res_ack  (i_res_ack),
        .o_res_data (o_res_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    ////////////////////////////////////////////////////////////
    // model and stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // scale times the ternary-weighted sum over all lanes and taps
    function automatic result_t model_result();
        int       total;
        feature_t f;
        int       fv;
        total = 0;
        for (int l = 0; l < `DLA_TN; l++) begin
            for (int t = 0; t < `DLA_TAPS; t++) begin
                f  = win_sh[l][t];
                fv = f;              // sign extend
                case (kern_sh[l][t])
                    2'b01:   total = total + fv;
                    2'b11:   total = total - fv;
                    default: total = total;  // 00 and 10 are zero
                endcase
            end
        end
        return result_t'(total * int'(scale_sh));
    endfunction

    function automatic window_t make_window(int base, int step);
        window_t w;
        for (int t = 0; t < `DLA_TAPS; t++)
            w[t] = feature_t'(base + t * step);
        return w;
    endfunction

    function automatic window_t random_window();
        window_t     w;
        logic [31:0] r;
        for (int t = 0; t < `DLA_TAPS; t++) begin
            r    = lcg_next();
            w[t] = r[15:8];  // upper bits mix better
        end
        return w;
    endfunction

    task automatic check_result(input string name, input result_t got, input result_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("CHECKS FAILED");
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // channel drivers entered and left on a falling edge
    ////////////////////////////////////////////////////////////

    task automatic send_cmd(input opcode_t op, input lane_idx_t lane, input window_t data);
        int n;
        n = 0;
        while (o_cmd_ack) begin  // previous handshake must be closed
            if (n >= WAIT_LIMIT)
                abort_run("o_cmd_ack stuck high before a command");
            @(negedge clk);
            n++;
        end
        i_cmd_op   = op;
        i_cmd_lane = lane;
        i_cmd_data = data;
        i_cmd_req  = 1'b1;
        n = 0;
        while (!o_cmd_ack) begin
            if (n >= WAIT_LIMIT)
                abort_run("o_cmd_ack never rose");
            @(negedge clk);
            n++;
        end
        i_cmd_req = 1'b0;
        n = 0;
        while (o_cmd_ack) begin
            if (n >= WAIT_LIMIT)
                abort_run("o_cmd_ack never fell after req dropped");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic take_result(input result_t exp, input string name);
        int n;
        n = 0;
        while (!o_res_req) begin
            if (n >= WAIT_LIMIT)
                abort_run("o_res_req never rose");
            @(negedge clk);
            n++;
        end
        check_result(name, o_res_data, exp);
        i_res_ack = 1'b1;
        n = 0;
        while (o_res_req) begin
            if (n >= WAIT_LIMIT)
                abort_run("o_res_req never fell after ack");
            @(negedge clk);
            n++;
        end
        i_res_ack = 1'b0;
    endtask

    task automatic load_weight(input lane_idx_t lane, input kernel_t k);
        logic [$bits(window_t)-1:0] bits;
        bits = '0;
        bits[$bits(kernel_t)-1:0] = k;  // kernel rides in the low bits
        kern_sh[lane] = k;
        send_cmd(OP_LOAD_WEIGHT, lane, bits);
    endtask

    task automatic load_feature(input lane_idx_t lane, input window_t w);
        win_sh[lane] = w;
        send_cmd(OP_LOAD_FEATURE, lane, w);
    endtask

    task automatic load_scale(input scale_t s);
        logic [$bits(window_t)-1:0] bits;
        bits = '0;
        bits[$bits(scale_t)-1:0] = s;
        scale_sh = s;
        send_cmd(OP_LOAD_SCALE, '0, bits);
    endtask

    task automatic run_and_check();
        result_t exp;
        exp = model_result();
        send_cmd(OP_RUN, '0, '0);
        take_result(exp, "o_res_data");
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before)
            $display("test %s done, no errors", name);
        else
            $display("test %s done, %0d errors", name, errors - err_before);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic run_after_reset();
        int e;
        e = errors;
        check_bit("o_cmd_ack", o_cmd_ack, 1'b0);
        check_bit("o_res_req", o_res_req, 1'b0);
        run_and_check();  // zero kernels give zero
        report_test("reset_run", e);
    endtask

    task automatic all_plus_sum();
        int       e;
        int       fsum;
        feature_t f;
        e    = errors;
        fsum = 0;
        for (int l = 0; l < `DLA_TN; l++) begin
            load_weight(lane_idx_t'(l), {`DLA_TAPS{TERN_PLUS}});
            load_feature(lane_idx_t'(l), make_window(l * 20 - 30, 7));
        end
        for (int l = 0; l < `DLA_TN; l++) begin
            for (int t = 0; t < `DLA_TAPS; t++) begin
                f    = win_sh[l][t];
                fsum = fsum + f;  // plain sum of every feature
            end
        end
        send_cmd(OP_RUN, '0, '0);
        take_result(result_t'(fsum), "o_res_data");
        report_test("all_plus", e);
    endtask

    task automatic mixed_codes();
        int      e;
        kernel_t k;
        tern_t   codes [4];
        e     = errors;
        codes = '{2'b00, 2'b01, 2'b11, 2'b10};  // code 10 must count as zero
        for (int l = 0; l < `DLA_TN; l++) begin
            for (int t = 0; t < `DLA_TAPS; t++)
                k[t] = codes[(t + l) % 4];
            load_weight(lane_idx_t'(l), k);
            load_feature(lane_idx_t'(l), make_window(-60 + l * 15, 11));
        end
        load_scale(-16'sd3);
        run_and_check();
        report_test("mixed", e);
    endtask

    task automatic single_lane_rewrite();
        int e;
        e = errors;
        load_feature(2'd2, make_window(100, -13));  // lane 2 only
        load_weight(2'd2, {`DLA_TAPS{TERN_MINUS}});
        run_and_check();
        report_test("one_lane", e);
    endtask

    task automatic random_traffic();
        int          e;
        logic [31:0] r;
        logic [31:0] v;
        e = errors;
        for (int i = 0; i < 20; i++) begin
            r = lcg_next();
            v = lcg_next();
            case (r % 3)
                0:       load_weight(r[9:8], v[17:0]);
                1:       load_feature(r[9:8], random_window());
                default: load_scale(v[23:8]);
            endcase
            run_and_check();
        end
        report_test("random", e);
    endtask

    task automatic backpressure_hold();
        int      e;
        int      n;
        result_t exp1;
        result_t exp2;
        e = errors;
        load_scale(16'sd5);
        load_weight(2'd1, {`DLA_TAPS{TERN_PLUS}});  // lane 1 counts every tap
        load_feature(2'd1, make_window(10, 3));
        exp1 = model_result();
        send_cmd(OP_RUN, '0, '0);                 // first result left pending
        load_feature(2'd1, make_window(-40, 5));  // rewrite during pending run
        exp2 = model_result();
        fork
            send_cmd(OP_RUN, '0, '0);     // held until busy clears
            begin
                n = 0;
                while (!o_res_req) begin
                    if (n >= WAIT_LIMIT)
                        abort_run("first result never raised o_res_req");
                    @(negedge clk);
                    n++;
                end
                repeat (20) begin         // ack withheld
                    @(negedge clk);
                    check_bit("o_cmd_ack", o_cmd_ack, 1'b0);
                    check_bit("o_res_req", o_res_req, 1'b1);
                end
                take_result(exp1, "o_res_data");
            end
        join
        take_result(exp2, "o_res_data");
        report_test("backpressure", e);
    endtask

    initial begin
        lcg_state  = 32'h25770baa;
        errors     = 0;
        checks     = 0;
        i_rst_n    = 1'b0;
        i_cmd_req  = 1'b0;
        i_cmd_op   = OP_LOAD_WEIGHT;
        i_cmd_lane = '0;
        i_cmd_data = '0;
        i_res_ack  = 1'b0;
        for (int l = 0; l < `DLA_TN; l++) begin
            kern_sh[l] = '0;
            win_sh[l]  = '0;
        end
        scale_sh = 16'sd1;  // reset value of the scaler
        repeat (5) @(negedge clk);
        i_rst_n = 1'b1;
        @(negedge clk);

        run_after_reset();
        all_plus_sum();
        mixed_codes();
        single_lane_rewrite();
        random_traffic();
        backpressure_hold();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+src
src/dla_pkg.sv
src/lane_load_if.sv
src/cmd_decode.sv
src/tern_lane.sv
src/chan_accum.sv
src/dla_top.sv
verif/dla_tb.sv
